/* all.f */
+incdir+dv
verilog/arb_cfg_pkg.sv
verilog/arb_types_pkg.sv
verilog/arb_rr_pick.sv
verilog/arb_grant_encode.sv
verilog/arbiter.sv
dv/tb_arbiter.sv

/* dv/tb_arbiter_vectors.svh */
// fixed stimulus rows for the arbiter testbench
// each row is {mode, enable, requests}, held for several cycles
`ifndef TB_ARBITER_VECTORS_SVH
`define TB_ARBITER_VECTORS_SVH

localparam int FIXED_ROWS = 24;

// columns: mode (rr or fixed), enable, request lines 7..0
localparam logic [ARB_WIDTH+1:0] FIXED_TABLE [FIXED_ROWS] = '{
	// idle after reset
	{ARB_MODE_RR,    1'b1, 8'b0000_0000},
	// single requesters, grant follows the only line
	{ARB_MODE_RR,    1'b1, 8'b0000_0001},
	{ARB_MODE_RR,    1'b1, 8'b0000_0100},
	{ARB_MODE_RR,    1'b1, 8'b0001_0000},
	{ARB_MODE_RR,    1'b1, 8'b1000_0000},
	{ARB_MODE_RR,    1'b1, 8'b0010_0000},
	// all lines request, line 5 stays parked
	{ARB_MODE_RR,    1'b1, 8'b1111_1111},
	{ARB_MODE_RR,    1'b1, 8'b1111_1111},
	// holder drops out each row, grant moves up and wraps 7 to 0
	{ARB_MODE_RR,    1'b1, 8'b1101_1111},
	{ARB_MODE_RR,    1'b1, 8'b1001_1111},
	{ARB_MODE_RR,    1'b1, 8'b0001_1111},
	{ARB_MODE_RR,    1'b1, 8'b0001_1110},
	{ARB_MODE_RR,    1'b1, 8'b1111_0000},
	// fixed priority preempts the line 4 holder
	{ARB_MODE_FIXED, 1'b1, 8'b1111_0010},
	{ARB_MODE_FIXED, 1'b1, 8'b1111_1000},
	{ARB_MODE_RR,    1'b1, 8'b1111_1000},
	// enable low masks everything, pointer kept at line 3
	{ARB_MODE_RR,    1'b0, 8'b1111_0000},
	{ARB_MODE_FIXED, 1'b0, 8'b1111_0000},
	// lines 0, 2 and 7 request, only a kept pointer picks line 7
	{ARB_MODE_RR,    1'b1, 8'b1000_0101},
	{ARB_MODE_RR,    1'b1, 8'b0000_0011},
	{ARB_MODE_RR,    1'b1, 8'b0000_0000},
	{ARB_MODE_RR,    1'b1, 8'b0000_1010},
	{ARB_MODE_RR,    1'b1, 8'b0100_0000},
	{ARB_MODE_RR,    1'b0, 8'b0000_0001}
};

`endif

/* dv/tb_arbiter.sv */
// testbench for the 8-line arbiter
// clock, reset, reference model, vector loop, grant monitor, report
`timescale 1ns/100ps

module tb_arbiter
	import arb_cfg_pkg::*, arb_types_pkg::*;
();

	`include "tb_arbiter_vectors.svh"

	localparam int RANDOM_ROWS  = 40;
	localparam int NUM_ROWS     = FIXED_ROWS + RANDOM_ROWS;
	localparam int HOLD_CYCLES  = 5;

	logic                     clock_i;
	logic                     rst_i;
	logic [ARB_WIDTH-1:0]     req_i;
	logic                     enable_i;
	arb_mode_e                mode_i;
	logic [ARB_WIDTH-1:0]     grant_o;
	logic [ARB_SEL_WIDTH-1:0] select_o;
	logic                     valid_o;

	// full stimulus table, fixed rows then random rows
	logic [ARB_WIDTH-1:0] row_req [NUM_ROWS];
	logic                 row_en [NUM_ROWS];
	arb_mode_e            row_mode [NUM_ROWS];

	integer seed;
	int     errors;
	int     unrequested_grants;
	int     multi_grants;

	// model state
	int                   model_ptr;
	logic [ARB_WIDTH-1:0] model_prev;
	logic [ARB_WIDTH-1:0] exp_grant;

	// masked requests seen on the last three falling edges
	logic [ARB_WIDTH-1:0] req_hist [3];

	arbiter arbiter_inst
	(
		.clock_i  (clock_i),
		.rst_i    (rst_i),
		.req_i    (req_i),
		.enable_i (enable_i),
		.mode_i   (mode_i),
		.grant_o  (grant_o),
		.select_o (select_o),
		.valid_o  (valid_o)
	);

	initial
	begin
		clock_i = 1'b0;
		forever #5 clock_i = ~clock_i;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s actual %0h expected %0h", $time, name, actual, expected);
			errors++;
		end
	endtask

	// expected grant from masked requests, mode, last grant and pointer
	function automatic logic [ARB_WIDTH-1:0] model_grant(input logic [ARB_WIDTH-1:0] reqs,
		input arb_mode_e mode, input logic [ARB_WIDTH-1:0] prev, input int ptr);
		logic [ARB_WIDTH-1:0] result;
		int                   line;
		result = '0;
		if (mode == ARB_MODE_FIXED)
		begin
			// walk down so the lowest set line is written last
			for (int i = ARB_WIDTH - 1; i >= 0; i--)
			begin
				if (reqs[i])
					result = ARB_WIDTH'(1) << i;
			end
		end
		else if (prev != '0 && (prev & reqs) == prev)
			result = prev;
		else
		begin
			for (int k = 1; k <= ARB_WIDTH; k++)
			begin
				line = (ptr + k) % ARB_WIDTH;
				if (reqs[line] && result == '0)
					result[line] = 1'b1;
			end
		end
		return result;
	endfunction

	function automatic int index_of(input logic [ARB_WIDTH-1:0] onehot);
		int idx;
		idx = 0;
		for (int i = 0; i < ARB_WIDTH; i++)
		begin
			if (onehot[i])
				idx = i;
		end
		return idx;
	endfunction

	// copy fixed rows, then draw the random ones
	task automatic build_rows();
		for (int r = 0; r < FIXED_ROWS; r++)
		begin
			row_req[r]  = FIXED_TABLE[r][ARB_WIDTH-1:0];
			row_en[r]   = FIXED_TABLE[r][ARB_WIDTH];
			row_mode[r] = arb_mode_e'(FIXED_TABLE[r][ARB_WIDTH+1]);
		end
		for (int r = FIXED_ROWS; r < NUM_ROWS; r++)
		begin
			row_req[r]  = ARB_WIDTH'($random(seed));
			// enable low about one row in four
			row_en[r]   = (($random(seed) & 3) != 0);
			row_mode[r] = arb_mode_e'($random(seed) & 1);
		end
	endtask

	// grant seen now belongs to requests seen three falling edges ago
	always @(negedge clock_i)
	begin
		req_hist[2] <= req_hist[1];
		req_hist[1] <= req_hist[0];
		req_hist[0] <= req_i & {ARB_WIDTH{enable_i}};
		if (!rst_i)
		begin
			if ((grant_o & ~req_hist[2]) != '0)
			begin
				$display("Fail at %0t ns: grant_o %b on a line not requesting %b",
					$time, grant_o, req_hist[2]);
				unrequested_grants++;
			end
			if (!$onehot0(grant_o))
			begin
				$display("Fail at %0t ns: grant_o %b has more than one line set", $time, grant_o);
				multi_grants++;
			end
		end
	end

	initial
	begin
		rst_i    = 1'b1;
		req_i    = '0;
		enable_i = 1'b0;
		mode_i   = ARB_MODE_RR;
		seed     = 54041;
		errors   = 0;
		unrequested_grants = 0;
		multi_grants       = 0;
		for (int i = 0; i < 3; i++)
			req_hist[i] = '0;
		build_rows();

		repeat (4) @(posedge clock_i);
		#1;
		rst_i = 1'b0;

		// idle state straight after reset
		check_value("grant_o after reset", grant_o, '0);
		check_value("select_o after reset", select_o, '0);
		check_value("valid_o after reset", valid_o, 1'b0);

		model_ptr  = ARB_WIDTH - 1;
		model_prev = '0;

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			req_i    = row_req[r];
			enable_i = row_en[r];
			mode_i   = row_mode[r];
			exp_grant = model_grant(row_en[r] ? row_req[r] : '0, row_mode[r],
				model_prev, model_ptr);
			if (exp_grant != '0)
				model_ptr = index_of(exp_grant);
			model_prev = exp_grant;

			for (int cyc = 1; cyc <= HOLD_CYCLES; cyc++)
			begin
				@(posedge clock_i);
				#1;
				// new grant must already be in place at the latency edge
				if (cyc == ARB_LATENCY)
					check_value("grant_o at latency", grant_o, exp_grant);
			end

			check_value("grant_o", grant_o, exp_grant);
			check_value("select_o", select_o, index_of(exp_grant));
			check_value("valid_o", valid_o, exp_grant != '0);
		end

		$display("errors: %0d value mismatches, %0d grants without request, %0d multiple grants",
			errors, unrequested_grants, multi_grants);
		if (errors == 0 && unrequested_grants == 0 && multi_grants == 0)
		begin
			$display("TEST OK");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* verilog/arb_cfg_pkg.sv */
// sizing constants for the 8-line request arbiter
// request count, select index width and request-to-grant latency
package arb_cfg_pkg;

	// number of request lines
	localparam int ARB_WIDTH = 8;

	// width of the binary select index, log2 of the line count
	localparam int ARB_SEL_WIDTH = $clog2(ARB_WIDTH);

	// edges from request sampling to registered grant
	// input register, pick register, grant register
	localparam int ARB_LATENCY = 3;

endpackage

/* verilog/arb_grant_encode.sv */
// output stage of the arbiter
// grant register, one-hot to binary select, valid flag
`timescale 1ns/100ps

module arb_grant_encode
	import arb_cfg_pkg::*;
(
	input  logic                     clock_i,
	input  logic                     rst_i,
	input  logic [ARB_WIDTH-1:0]     pick_i,
	output logic [ARB_WIDTH-1:0]     grant_o,
	output logic [ARB_SEL_WIDTH-1:0] select_o,
	output logic                     valid_o
);

	logic [ARB_WIDTH-1:0]     grant_q;
	logic [ARB_SEL_WIDTH-1:0] select_q;
	logic                     valid_q;

	// binary index of the picked line
	logic [ARB_SEL_WIDTH-1:0] sel_d;

	// or-encoding, gives zero for an empty pick
	always_comb
	begin
		sel_d = '0;
		for (int i = 0; i < ARB_WIDTH; i++)
		begin
			if (pick_i[i])
				sel_d = sel_d | ARB_SEL_WIDTH'(i);
		end
	end

	// all three outputs change on the same edge
	always_ff @(posedge clock_i)
	begin
		if (rst_i)
		begin
			grant_q  <= '0;
			select_q <= '0;
			valid_q  <= 1'b0;
		end
		else
		begin
			grant_q  <= pick_i;
			select_q <= sel_d;
			valid_q  <= |pick_i;
		end
	end

	assign grant_o  = grant_q;
	assign select_o = select_q;
	assign valid_o  = valid_q;

	// grant is one-hot or idle
	assert property (@(posedge clock_i) disable iff (rst_i)
		$onehot0(grant_o));

	// valid tracks a nonzero grant
	assert property (@(posedge clock_i) disable iff (rst_i)
		valid_o == (grant_o != '0));

	// select points at the granted line
	assert property (@(posedge clock_i) disable iff (rst_i)
		valid_o |-> grant_o[select_o]);

endmodule

/* verilog/arb_rr_pick.sv */
// request search stage of the arbiter
// input register with enable mask, last-grant pointer,
// round-robin search with parking, fixed priority, pick register
`timescale 1ns/100ps

module arb_rr_pick
	import arb_cfg_pkg::*, arb_types_pkg::*;
(
	input  logic                 clock_i,
	input  logic                 rst_i,
	input  logic [ARB_WIDTH-1:0] req_i,
	input  logic                 enable_i,
	input  arb_mode_e            mode_i,
	input  logic [ARB_WIDTH-1:0] grant_i,
	input  logic                 valid_i,
	output logic [ARB_WIDTH-1:0] pick_o
);

	// registered masked requests and mode
	logic [ARB_WIDTH-1:0]     req_q;
	arb_mode_e                mode_q;

	// index of the most recent nonzero grant
	logic [ARB_SEL_WIDTH-1:0] ptr_q;
	logic [ARB_SEL_WIDTH-1:0] grant_idx;
	logic [ARB_SEL_WIDTH-1:0] start_idx;

	// rotated search vectors
	logic [2*ARB_WIDTH-1:0]   req_dbl;
	logic [ARB_WIDTH-1:0]     req_rot;
	logic [ARB_WIDTH-1:0]     pick_rot;
	logic [2*ARB_WIDTH-1:0]   pick_dbl;

	logic [ARB_WIDTH-1:0]     rr_pick;
	logic [ARB_WIDTH-1:0]     fixed_pick;
	logic                     park;
	logic [ARB_WIDTH-1:0]     pick_d;

	// isolate the lowest set bit, zero stays zero
	function automatic logic [ARB_WIDTH-1:0] lowest_set(input logic [ARB_WIDTH-1:0] v);
		return v & (~v + ARB_WIDTH'(1));
	endfunction

	// sample requests, enable clears the whole set
	always_ff @(posedge clock_i)
	begin
		if (rst_i)
		begin
			req_q  <= '0;
			mode_q <= ARB_MODE_RR;
		end
		else
		begin
			req_q  <= req_i & {ARB_WIDTH{enable_i}};
			mode_q <= mode_i;
		end
	end

	// binary index of the fed-back grant
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < ARB_WIDTH; i++)
		begin
			if (grant_i[i])
				grant_idx = grant_idx | ARB_SEL_WIDTH'(i);
		end
	end

	// pointer only moves on a real grant, so a gap with no
	// requests (or enable low) keeps the search position
	always_ff @(posedge clock_i)
	begin
		if (rst_i)
			ptr_q <= ARB_SEL_WIDTH'(ARB_WIDTH-1);
		else if (valid_i)
			ptr_q <= grant_idx;
	end

	// search starts one above the last grant, wrapping past the top line
	assign start_idx = (ptr_q == ARB_SEL_WIDTH'(ARB_WIDTH-1)) ? '0 : ptr_q + 1'b1;

	// rotate so the start line sits at bit 0, take the first set bit,
	// then rotate the result back into place
	assign req_dbl  = {req_q, req_q} >> start_idx;
	assign req_rot  = req_dbl[ARB_WIDTH-1:0];
	assign pick_rot = lowest_set(req_rot);
	assign pick_dbl = {pick_rot, pick_rot} << start_idx;
	assign rr_pick  = pick_dbl[2*ARB_WIDTH-1:ARB_WIDTH];

	// lowest line wins
	assign fixed_pick = lowest_set(req_q);

	// current holder still requesting
	assign park = valid_i && ((grant_i & req_q) != '0);

	always_comb
	begin
		if (mode_q == ARB_MODE_FIXED)
			pick_d = fixed_pick;
		else if (park)
			pick_d = grant_i;
		else
			pick_d = rr_pick;   // zero when no line requests
	end

	always_ff @(posedge clock_i)
	begin
		if (rst_i)
			pick_o <= '0;
		else
			pick_o <= pick_d;
	end

	// at most one line picked
	assert property (@(posedge clock_i) disable iff (rst_i)
		$onehot0(pick_o));

	// a grant coming back from the output stage belongs to a line
	// that was requesting with enable high when it was sampled
	assert property (@(posedge clock_i) disable iff (rst_i)
		(grant_i & ~$past(req_i & {ARB_WIDTH{enable_i}}, ARB_LATENCY)) == '0);

endmodule

/* verilog/arb_types_pkg.sv */
// arbitration policy opcode
package arb_types_pkg;

	// policy select on mode_i
	// rr keeps a granted line while it requests (parking),
	// then searches upward from the line after the last grant
	// fixed always grants the lowest requesting line and may preempt
	typedef enum logic
	{
		ARB_MODE_RR    = 1'b0,
		ARB_MODE_FIXED = 1'b1
	} arb_mode_e;

endpackage

/* verilog/arbiter.sv */
// top level of the 8-line request arbiter
// pick stage and output stage, with grant and valid fed back
// for parking and the last-grant pointer
`timescale 1ns/100ps

module arbiter
	import arb_cfg_pkg::*, arb_types_pkg::*;
(
	input  logic                     clock_i,
	input  logic                     rst_i,
	input  logic [ARB_WIDTH-1:0]     req_i,
	input  logic                     enable_i,
	input  arb_mode_e                mode_i,
	output logic [ARB_WIDTH-1:0]     grant_o,
	output logic [ARB_SEL_WIDTH-1:0] select_o,
	output logic                     valid_o
);

	// one-hot or zero search result between the stages
	logic [ARB_WIDTH-1:0] pick_oh;

	// request register and search, two edges of the latency
	arb_rr_pick arb_rr_pick_inst
	(
		.clock_i  (clock_i),
		.rst_i    (rst_i),
		.req_i    (req_i),
		.enable_i (enable_i),
		.mode_i   (mode_i),
		// output grant comes back as the parking candidate
		.grant_i  (grant_o),
		.valid_i  (valid_o),
		.pick_o   (pick_oh)
	);

	// registered grant, select and valid, third edge
	arb_grant_encode arb_grant_encode_inst
	(
		.clock_i  (clock_i),
		.rst_i    (rst_i),
		.pick_i   (pick_oh),
		.grant_o  (grant_o),
		.select_o (select_o),
		.valid_o  (valid_o)
	);

endmodule
